// ==== hdl/vdp_pkg.sv ====
package vdp_pkg;

    typedef logic [15:0] word_t;        // vram, register and palette word
    typedef logic [15:0] vaddr_t;       // vram word address
    typedef logic  [7:0] byte_t;        // host bus byte
    typedef logic  [3:0] reg_num_t;     // host register number
    typedef logic  [3:0] nib_mask_t;    // one enable per nibble
    typedef logic  [7:0] color_idx_t;   // palette index
    typedef logic [11:0] rgb_t;         // 4:4:4 colour
    typedef logic  [3:0] intr_t;        // interrupt bits
    typedef logic  [7:0] coord_t;       // display counter

    // host register map
    localparam reg_num_t REG_VRAM_ADDR   = 4'h0;
    localparam reg_num_t REG_VRAM_DATA   = 4'h1;
    localparam reg_num_t REG_WR_MASK     = 4'h2;
    localparam reg_num_t REG_PAL_ADDR    = 4'h3;
    localparam reg_num_t REG_PAL_DATA    = 4'h4;
    localparam reg_num_t REG_INTR_MASK   = 4'h5;
    localparam reg_num_t REG_INTR_CLEAR  = 4'h6;   // write clears, read gives status
    localparam reg_num_t REG_INTR_SIGNAL = 4'h7;

    // tiny frame, pixels and lines
    localparam int H_VISIBLE    = 16;
    localparam int H_SYNC_START = 18;
    localparam int H_SYNC_END   = 20;
    localparam int H_TOTAL      = 24;
    localparam int V_VISIBLE    = 8;
    localparam int V_SYNC_START = 9;
    localparam int V_SYNC_END   = 10;
    localparam int V_TOTAL      = 12;

    localparam int WORDS_PER_LINE = H_VISIBLE / 2;  // two pixels per word

    localparam int VRAM_WORDS  = 256;               // short vram, address wraps
    localparam int VRAM_AW     = $clog2(VRAM_WORDS);
    localparam int PAL_ENTRIES = 256;

    localparam int INTR_VBLANK = 0;                 // raised at start of vsync

    typedef enum logic [1:0] {
        IDLE,
        VRAM_WRITE,
        VRAM_READ,
        PAL_WRITE
    } regs_state_e;

endpackage

// ==== hdl/vram_port_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// one requester's path into vram
interface vram_port_if;
    logic               sel;        // request, held until grant
    logic               wr;         // 1 = write, 0 = read
    vdp_pkg::nib_mask_t mask;       // nibble write enables
    vdp_pkg::vaddr_t    addr;
    vdp_pkg::word_t     wdata;
    logic               grant;      // request taken this cycle
    vdp_pkg::word_t     rdata;
    logic               rd_valid;   // rdata good one cycle after a read grant

    modport requester(output sel, wr, mask, addr, wdata,
                      input  grant, rdata, rd_valid);

    modport memory(input  sel, wr, mask, addr, wdata,
                   output grant, rdata, rd_valid);
endinterface

`default_nettype wire

// ==== hdl/vdp_regs.sv ====
`default_nettype none
`timescale 1ns/1ps

module vdp_regs(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,     // access strobe, active low
    input  wire logic               bus_rd_nwr_i,   // 1 = read
    input  wire vdp_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic               bus_bytesel_i,  // 0 = high byte, 1 = low byte
    input  wire vdp_pkg::byte_t     bus_data_i,
    output vdp_pkg::byte_t          bus_data_o,
    vram_port_if.requester          vram,
    output logic                    pal_wr_o,
    output vdp_pkg::color_idx_t     pal_addr_o,
    output vdp_pkg::word_t          pal_data_o,
    output vdp_pkg::intr_t          intr_mask_o,
    output vdp_pkg::intr_t          intr_clear_o,   // one-cycle strobe
    output vdp_pkg::intr_t          intr_signal_o,  // one-cycle strobe
    input  wire vdp_pkg::intr_t     intr_status_i
);

vdp_pkg::regs_state_e   state_q;
vdp_pkg::byte_t         hi_q;           // even byte waiting for its odd half
vdp_pkg::vaddr_t        vram_addr_q;
vdp_pkg::word_t         vram_data_q;    // write data, then prefetched word
vdp_pkg::nib_mask_t     wr_mask_q;
vdp_pkg::word_t         wr_word;
vdp_pkg::word_t         rd_word;
logic                   wr_acc;
logic                   rd_acc;
logic                   vram_start;

assign wr_acc  = !bus_cs_n_i && !bus_rd_nwr_i;
assign rd_acc  = !bus_cs_n_i && bus_rd_nwr_i;
assign wr_word = {hi_q, bus_data_i};

// host accesses that kick off vram traffic
assign vram_start = bus_bytesel_i &&
                    ((wr_acc && (bus_reg_num_i == vdp_pkg::REG_VRAM_ADDR ||
                                 bus_reg_num_i == vdp_pkg::REG_VRAM_DATA)) ||
                     (rd_acc && bus_reg_num_i == vdp_pkg::REG_VRAM_DATA));

assign vram.sel   = (state_q == vdp_pkg::VRAM_WRITE) || (state_q == vdp_pkg::VRAM_READ);
assign vram.wr    = (state_q == vdp_pkg::VRAM_WRITE);
assign vram.mask  = wr_mask_q;
assign vram.addr  = vram_addr_q;
assign vram.wdata = vram_data_q;
assign pal_wr_o   = (state_q == vdp_pkg::PAL_WRITE);   // one cycle only

// read mux, byte picked on the clock
always_comb begin
    case (bus_reg_num_i)
        vdp_pkg::REG_VRAM_ADDR:  rd_word = vram_addr_q;
        vdp_pkg::REG_VRAM_DATA:  rd_word = vram_data_q;
        vdp_pkg::REG_WR_MASK:    rd_word = {12'h000, wr_mask_q};
        vdp_pkg::REG_PAL_ADDR:   rd_word = {8'h00, pal_addr_o};
        vdp_pkg::REG_INTR_MASK:  rd_word = {12'h000, intr_mask_o};
        vdp_pkg::REG_INTR_CLEAR: rd_word = {12'h000, intr_status_i};  // status view
        default:                 rd_word = '0;
    endcase
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        state_q       <= vdp_pkg::IDLE;
        vram_addr_q   <= '0;
        wr_mask_q     <= '1;            // all nibbles written
        pal_addr_o    <= '0;
        intr_mask_o   <= '0;
        intr_clear_o  <= '0;
        intr_signal_o <= '0;
    end else begin
        intr_clear_o  <= '0;
        intr_signal_o <= '0;
        case (state_q)
            vdp_pkg::VRAM_WRITE: if (vram.grant) begin
                vram_addr_q <= vram_addr_q + 1'b1;  // auto-increment
                state_q     <= vdp_pkg::VRAM_READ;  // then prefetch new address
            end
            vdp_pkg::VRAM_READ: if (vram.grant) begin
                state_q <= vdp_pkg::IDLE;           // data lands via rd_valid
            end
            vdp_pkg::PAL_WRITE: begin
                pal_addr_o <= pal_addr_o + 1'b1;
                state_q    <= vdp_pkg::IDLE;
            end
            default: ;
        endcase
        if (wr_acc && bus_bytesel_i) begin
            case (bus_reg_num_i)
                vdp_pkg::REG_VRAM_ADDR: begin
                    vram_addr_q <= wr_word;
                    state_q     <= vdp_pkg::VRAM_READ;
                end
                vdp_pkg::REG_VRAM_DATA:   state_q       <= vdp_pkg::VRAM_WRITE;
                vdp_pkg::REG_WR_MASK:     wr_mask_q     <= wr_word[3:0];
                vdp_pkg::REG_PAL_ADDR:    pal_addr_o    <= wr_word[7:0];
                vdp_pkg::REG_PAL_DATA:    state_q       <= vdp_pkg::PAL_WRITE;
                vdp_pkg::REG_INTR_MASK:   intr_mask_o   <= wr_word[3:0];
                vdp_pkg::REG_INTR_CLEAR:  intr_clear_o  <= wr_word[3:0];
                vdp_pkg::REG_INTR_SIGNAL: intr_signal_o <= wr_word[3:0];
                default: ;
            endcase
        end
        // odd read of data steps on to the next word
        if (rd_acc && bus_bytesel_i && bus_reg_num_i == vdp_pkg::REG_VRAM_DATA) begin
            vram_addr_q <= vram_addr_q + 1'b1;
            state_q     <= vdp_pkg::VRAM_READ;
        end
    end
end

// data path
always_ff @(posedge clk) begin
    if (wr_acc && !bus_bytesel_i) begin
        hi_q <= bus_data_i;
    end
    if (wr_acc && bus_bytesel_i && bus_reg_num_i == vdp_pkg::REG_VRAM_DATA) begin
        vram_data_q <= wr_word;
    end
    if (wr_acc && bus_bytesel_i && bus_reg_num_i == vdp_pkg::REG_PAL_DATA) begin
        pal_data_o <= wr_word;
    end
    if (vram.rd_valid) begin
        vram_data_q <= vram.rdata;      // prefetch result
    end
    if (rd_acc) begin
        bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[15:8];
    end
end

// host must let the previous vram job finish
assert property (@(posedge clk) disable iff (reset_i)
    vram_start |-> state_q == vdp_pkg::IDLE);

endmodule

`default_nettype wire

// ==== hdl/vram_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module vram_arbiter(
    input  wire logic   clk,
    input  wire logic   reset_i,
    vram_port_if.memory vid,    // video fetch, always wins
    vram_port_if.memory cpu     // host side
);

vdp_pkg::word_t     mem [vdp_pkg::VRAM_WORDS];
vdp_pkg::word_t     rdata_q;
logic               go;         // some port granted
logic               go_wr;
vdp_pkg::nib_mask_t go_mask;
vdp_pkg::vaddr_t    go_addr;
vdp_pkg::word_t     go_wdata;
logic [vdp_pkg::VRAM_AW-1:0] idx;
logic               vid_rv_q;
logic               cpu_rv_q;

// fixed priority, cpu only in cycles video leaves free
assign vid.grant = vid.sel;
assign cpu.grant = cpu.sel && !vid.sel;

always_comb begin
    go = vid.sel || cpu.sel;
    if (vid.sel) begin
        go_wr    = vid.wr;
        go_mask  = vid.mask;
        go_addr  = vid.addr;
        go_wdata = vid.wdata;
    end else begin
        go_wr    = cpu.wr;
        go_mask  = cpu.mask;
        go_addr  = cpu.addr;
        go_wdata = cpu.wdata;
    end
end

assign idx = go_addr[vdp_pkg::VRAM_AW-1:0];    // upper bits wrap

always_ff @(posedge clk) begin
    if (go && go_wr) begin
        for (int n = 0; n < 4; n++) begin
            if (go_mask[n]) begin
                mem[idx][n*4 +: 4] <= go_wdata[n*4 +: 4];   // masked nibbles only
            end
        end
    end
    if (go && !go_wr) begin
        rdata_q <= mem[idx];
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vid_rv_q <= 1'b0;
        cpu_rv_q <= 1'b0;
    end else begin
        vid_rv_q <= vid.grant && !vid.wr;
        cpu_rv_q <= cpu.grant && !cpu.wr;
    end
end

assign vid.rdata    = rdata_q;  // shared read register
assign cpu.rdata    = rdata_q;
assign vid.rd_valid = vid_rv_q;
assign cpu.rd_valid = cpu_rv_q;

// video leaves the next slot free, so a waiting cpu request gets in
assert property (@(posedge clk) disable iff (reset_i) vid.sel |=> !vid.sel);

endmodule

`default_nettype wire

// ==== hdl/video_scan.sv ====
`default_nettype none
`timescale 1ns/1ps

module video_scan(
    input  wire logic           clk,
    input  wire logic           reset_i,
    vram_port_if.requester      vram,
    output vdp_pkg::color_idx_t color_idx_o,    // pixel x, one cycle after its fetch
    output logic                hsync_o,
    output logic                vsync_o,
    output logic                de_o,
    output logic                vblank_o        // single pulse at vsync start
);

vdp_pkg::coord_t        h_q;
vdp_pkg::coord_t        v_q;
vdp_pkg::color_idx_t    lo_q;       // odd pixel of the last word
logic                   h_end;
logic                   visible;

assign h_end   = (h_q == vdp_pkg::coord_t'(vdp_pkg::H_TOTAL - 1));
assign visible = (h_q < vdp_pkg::H_VISIBLE) && (v_q < vdp_pkg::V_VISIBLE);

// one word per even pixel
assign vram.sel   = visible && !h_q[0];
assign vram.wr    = 1'b0;
assign vram.mask  = '0;
assign vram.wdata = '0;
assign vram.addr  = vdp_pkg::vaddr_t'(v_q) * vdp_pkg::vaddr_t'(vdp_pkg::WORDS_PER_LINE) +
                    vdp_pkg::vaddr_t'(h_q[7:1]);

assign vblank_o = (v_q == vdp_pkg::coord_t'(vdp_pkg::V_SYNC_START)) && (h_q == '0);

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_q     <= vdp_pkg::coord_t'(vdp_pkg::H_TOTAL - 1);    // park in blanking
        v_q     <= vdp_pkg::coord_t'(vdp_pkg::V_TOTAL - 1);
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        de_o    <= 1'b0;
    end else begin
        h_q <= h_end ? '0 : h_q + 1'b1;
        if (h_end) begin
            v_q <= (v_q == vdp_pkg::coord_t'(vdp_pkg::V_TOTAL - 1)) ? '0 : v_q + 1'b1;
        end
        // delayed one cycle to match the returned word
        hsync_o <= (h_q >= vdp_pkg::H_SYNC_START) && (h_q < vdp_pkg::H_SYNC_END);
        vsync_o <= (v_q >= vdp_pkg::V_SYNC_START) && (v_q < vdp_pkg::V_SYNC_END);
        de_o    <= visible;
    end
end

always_ff @(posedge clk) begin
    if (vram.rd_valid) begin
        lo_q <= vram.rdata[7:0];
    end
end

// high byte straight from vram, low byte one cycle later
assign color_idx_o = vram.rd_valid ? vram.rdata[15:8] : lo_q;

// fetch is never held off by the host
assert property (@(posedge clk) disable iff (reset_i)
    vram.sel |-> vram.grant ##1 vram.rd_valid);

endmodule

`default_nettype wire

// ==== hdl/palette_out.sv ====
`default_nettype none
`timescale 1ns/1ps

module palette_out(
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   pal_wr_i,
    input  wire vdp_pkg::color_idx_t    pal_addr_i,
    input  wire vdp_pkg::word_t         pal_data_i,
    input  wire vdp_pkg::color_idx_t    color_idx_i,
    input  wire logic                   hsync_i,
    input  wire logic                   vsync_i,
    input  wire logic                   de_i,
    output logic                  [3:0] red_o,
    output logic                  [3:0] green_o,
    output logic                  [3:0] blue_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        dv_de_o
);

vdp_pkg::word_t pal_mem [vdp_pkg::PAL_ENTRIES];
vdp_pkg::rgb_t  rgb_q;

always_ff @(posedge clk) begin
    if (pal_wr_i) begin
        pal_mem[pal_addr_i] <= pal_data_i;
    end
end

// lookup and sync share one register stage
always_ff @(posedge clk) begin
    if (reset_i) begin
        rgb_q   <= '0;
        hsync_o <= 1'b0;
        vsync_o <= 1'b0;
        dv_de_o <= 1'b0;
    end else begin
        rgb_q   <= de_i ? pal_mem[color_idx_i][11:0] : '0;   // black in blanking
        hsync_o <= hsync_i;
        vsync_o <= vsync_i;
        dv_de_o <= de_i;
    end
end

assign red_o   = rgb_q[11:8];
assign green_o = rgb_q[7:4];
assign blue_o  = rgb_q[3:0];

endmodule

`default_nettype wire

// ==== hdl/intr_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module intr_ctrl(
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire vdp_pkg::intr_t mask_i,     // enabled sources
    input  wire vdp_pkg::intr_t clear_i,    // strobe from host
    input  wire vdp_pkg::intr_t signal_i,   // strobe from host
    input  wire logic           vblank_i,
    output vdp_pkg::intr_t      status_o,   // pending bits
    output logic                bus_intr_o
);

vdp_pkg::intr_t sig;

always_comb begin
    sig = signal_i;
    sig[vdp_pkg::INTR_VBLANK] = signal_i[vdp_pkg::INTR_VBLANK] | vblank_i;
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        status_o   <= '0;
        bus_intr_o <= 1'b0;
    end else begin
        bus_intr_o <= |(sig & mask_i & ~status_o);     // only on newly pending bits
        status_o   <= (status_o | sig) & ~clear_i;
    end
end

assert property (@(posedge clk) disable iff (reset_i) bus_intr_o |-> mask_i != '0);

endmodule

`default_nettype wire

// ==== hdl/vdp_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module vdp_top(
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               bus_cs_n_i,
    input  wire logic               bus_rd_nwr_i,
    input  wire vdp_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic               bus_bytesel_i,
    input  wire vdp_pkg::byte_t     bus_data_i,
    output vdp_pkg::byte_t          bus_data_o,
    output logic                    bus_intr_o,
    output logic              [3:0] red_o,
    output logic              [3:0] green_o,
    output logic              [3:0] blue_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o
);

logic                   pal_wr;
vdp_pkg::color_idx_t    pal_addr;
vdp_pkg::word_t         pal_data;
vdp_pkg::intr_t         intr_mask;
vdp_pkg::intr_t         intr_clear;
vdp_pkg::intr_t         intr_signal;
vdp_pkg::intr_t         intr_status;
logic                   vblank;
vdp_pkg::color_idx_t    color_idx;
logic                   hsync_raw;  // aligned with color_idx, one stage early
logic                   vsync_raw;
logic                   de_raw;

vram_port_if vid_port();
vram_port_if cpu_port();

vdp_regs vdp_regs_i(
    .clk            (clk),
    .reset_i        (reset_i),
    .bus_cs_n_i     (bus_cs_n_i),
    .bus_rd_nwr_i   (bus_rd_nwr_i),
    .bus_reg_num_i  (bus_reg_num_i),
    .bus_bytesel_i  (bus_bytesel_i),
    .bus_data_i     (bus_data_i),
    .bus_data_o     (bus_data_o),
    .vram           (cpu_port.requester),
    .pal_wr_o       (pal_wr),
    .pal_addr_o     (pal_addr),
    .pal_data_o     (pal_data),
    .intr_mask_o    (intr_mask),
    .intr_clear_o   (intr_clear),
    .intr_signal_o  (intr_signal),
    .intr_status_i  (intr_status)
);

vram_arbiter vram_arbiter_i(
    .clk        (clk),
    .reset_i    (reset_i),
    .vid        (vid_port.memory),
    .cpu        (cpu_port.memory)
);

video_scan video_scan_i(
    .clk            (clk),
    .reset_i        (reset_i),
    .vram           (vid_port.requester),
    .color_idx_o    (color_idx),
    .hsync_o        (hsync_raw),
    .vsync_o        (vsync_raw),
    .de_o           (de_raw),
    .vblank_o       (vblank)
);

palette_out palette_out_i(
    .clk            (clk),
    .reset_i        (reset_i),
    .pal_wr_i       (pal_wr),
    .pal_addr_i     (pal_addr),
    .pal_data_i     (pal_data),
    .color_idx_i    (color_idx),
    .hsync_i        (hsync_raw),
    .vsync_i        (vsync_raw),
    .de_i           (de_raw),
    .red_o          (red_o),
    .green_o        (green_o),
    .blue_o         (blue_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o)
);

intr_ctrl intr_ctrl_i(
    .clk        (clk),
    .reset_i    (reset_i),
    .mask_i     (intr_mask),
    .clear_i    (intr_clear),
    .signal_i   (intr_signal),
    .vblank_i   (vblank),
    .status_o   (intr_status),
    .bus_intr_o (bus_intr_o)
);

endmodule

`default_nettype wire

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;    // 50% duty
end

endmodule

// ==== testbench/vdp_tb.sv ====
`timescale 1ns/1ps

module vdp_tb;

localparam int FRAME_CYCLES = vdp_pkg::H_TOTAL * vdp_pkg::V_TOTAL;
localparam int TEST_LIMIT   = 4 * FRAME_CYCLES + 2000;    // per test budget
localparam int FRAME_WORDS  = vdp_pkg::V_VISIBLE * vdp_pkg::WORDS_PER_LINE;
localparam int FRAME_PIXELS = vdp_pkg::V_VISIBLE * vdp_pkg::H_VISIBLE;
localparam int LOAD_GAP     = 4;    // odd bytes 6 cycles apart, enough for writes

logic                   clk;
logic                   reset;
logic                   bus_cs_n;
logic                   bus_rd_nwr;
vdp_pkg::reg_num_t      bus_reg_num;
logic                   bus_bytesel;
vdp_pkg::byte_t         bus_wdata;
vdp_pkg::byte_t         bus_rdata;
logic                   bus_intr;
logic             [3:0] red;
logic             [3:0] green;
logic             [3:0] blue;
logic                   hsync;
logic                   vsync;
logic                   dv_de;

logic [31:0]            lfsr_q = 32'hf4c9_5a9e;
string                  test_name = "reset";
int                     test_errors = 0;
int                     total_errors = 0;
int                     tests_run = 0;
int                     tests_ok = 0;
int                     cycles_in_test = 0;     // cleared at each test start
int                     intr_high_cycles = 0;   // bus_intr samples seen high
vdp_pkg::word_t         pal_model [vdp_pkg::PAL_ENTRIES];
vdp_pkg::word_t         frame_model [FRAME_WORDS];

tb_clock tb_clock_i(.clk(clk));

vdp_top vdp_top_i(
    .clk            (clk),
    .reset_i        (reset),
    .bus_cs_n_i     (bus_cs_n),
    .bus_rd_nwr_i   (bus_rd_nwr),
    .bus_reg_num_i  (bus_reg_num),
    .bus_bytesel_i  (bus_bytesel),
    .bus_data_i     (bus_wdata),
    .bus_data_o     (bus_rdata),
    .bus_intr_o     (bus_intr),
    .red_o          (red),
    .green_o        (green),
    .blue_o         (blue),
    .hsync_o        (hsync),
    .vsync_o        (vsync),
    .dv_de_o        (dv_de)
);

// taps 32,22,2,1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);     // one step per bit
        v = {v[30:0], lfsr_q[0]};
    end
    return v;
endfunction

// called on a falling edge, returns on one
task automatic bus_write_word(input vdp_pkg::reg_num_t reg_num, input vdp_pkg::word_t data,
                              input int gap = 6);
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = 1'b0;
    bus_reg_num = reg_num;
    bus_bytesel = 1'b0;         // high byte into the latch
    bus_wdata   = data[15:8];
    @(negedge clk);
    bus_bytesel = 1'b1;         // low byte fires the action
    bus_wdata   = data[7:0];
    @(negedge clk);
    bus_cs_n    = 1'b1;
    repeat (gap) @(negedge clk);
endtask

task automatic bus_read_word(input vdp_pkg::reg_num_t reg_num, output vdp_pkg::word_t data,
                             input int gap = 6);
    bus_cs_n    = 1'b0;
    bus_rd_nwr  = 1'b1;
    bus_reg_num = reg_num;
    bus_bytesel = 1'b0;
    @(negedge clk);
    data[15:8]  = bus_rdata;    // registered, valid one cycle on
    bus_bytesel = 1'b1;
    @(negedge clk);
    data[7:0]   = bus_rdata;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b0;
    repeat (gap) @(negedge clk);
endtask

task automatic check_value(input string what, input vdp_pkg::word_t expected,
                           input vdp_pkg::word_t actual);
    assert (actual == expected) else begin
        $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
        test_errors++;
    end
endtask

// counter settles on the falling edge, read it on the rising one
task automatic intr_count_at_edge(output int n);
    @(posedge clk);
    n = intr_high_cycles;
    @(negedge clk);
endtask

task automatic start_test(input string name);
    test_name      = name;
    test_errors    = 0;
    cycles_in_test = 0;
endtask

task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
        tests_ok++;
        $display("ok    %s", test_name);
    end else begin
        $display("FAIL  %s with %0d errors", test_name, test_errors);
    end
endtask

task automatic test_vram_rw();
    vdp_pkg::word_t written [16];
    vdp_pkg::word_t got;
    start_test("vram_rw");
    bus_write_word(vdp_pkg::REG_WR_MASK, 16'h000f);
    bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h0080);
    for (int i = 0; i < 16; i++) begin
        written[i] = vdp_pkg::word_t'(rand_bits(16));
        bus_write_word(vdp_pkg::REG_VRAM_DATA, written[i]);     // address steps on its own
    end
    bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h0080);           // rewind, prefetch first
    for (int i = 0; i < 16; i++) begin
        bus_read_word(vdp_pkg::REG_VRAM_DATA, got);
        check_value($sformatf("word %0d", i), written[i], got);
    end
    finish_test();
endtask

task automatic test_nibble_mask();
    vdp_pkg::word_t    old_w;
    vdp_pkg::word_t    new_w;
    vdp_pkg::word_t    expected;
    vdp_pkg::word_t    got;
    vdp_pkg::nib_mask_t m;
    start_test("nibble_mask");
    for (int r = 0; r < 4; r++) begin
        old_w = vdp_pkg::word_t'(rand_bits(16));
        new_w = vdp_pkg::word_t'(rand_bits(16));
        m     = vdp_pkg::nib_mask_t'(rand_bits(4));
        bus_write_word(vdp_pkg::REG_WR_MASK, 16'h000f);
        bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h00a0);
        bus_write_word(vdp_pkg::REG_VRAM_DATA, old_w);
        bus_write_word(vdp_pkg::REG_WR_MASK, {12'h000, m});
        bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h00a0);
        bus_write_word(vdp_pkg::REG_VRAM_DATA, new_w);          // only masked nibbles land
        bus_write_word(vdp_pkg::REG_WR_MASK, 16'h000f);
        bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h00a0);
        bus_read_word(vdp_pkg::REG_VRAM_DATA, got);
        for (int n = 0; n < 4; n++) begin
            expected[n*4 +: 4] = m[n] ? new_w[n*4 +: 4] : old_w[n*4 +: 4];
        end
        check_value($sformatf("mask %h", m), expected, got);
    end
    finish_test();
endtask

task automatic test_reg_readback();
    vdp_pkg::word_t v_addr;
    vdp_pkg::word_t v_mask;
    vdp_pkg::word_t v_pal;
    vdp_pkg::word_t v_imask;
    vdp_pkg::word_t got;
    start_test("reg_readback");
    v_addr  = vdp_pkg::word_t'(rand_bits(16));
    v_mask  = vdp_pkg::word_t'(rand_bits(16));
    v_pal   = vdp_pkg::word_t'(rand_bits(16));
    v_imask = vdp_pkg::word_t'(rand_bits(16));
    bus_write_word(vdp_pkg::REG_VRAM_ADDR, v_addr);
    bus_write_word(vdp_pkg::REG_WR_MASK, v_mask);
    bus_write_word(vdp_pkg::REG_PAL_ADDR, v_pal);
    bus_write_word(vdp_pkg::REG_INTR_MASK, v_imask);
    bus_read_word(vdp_pkg::REG_VRAM_ADDR, got);
    check_value("vram_addr", v_addr, got);
    bus_read_word(vdp_pkg::REG_WR_MASK, got);
    check_value("wr_mask", {12'h000, v_mask[3:0]}, got);    // 4 bits held
    bus_read_word(vdp_pkg::REG_PAL_ADDR, got);
    check_value("pal_addr", {8'h00, v_pal[7:0]}, got);
    bus_read_word(vdp_pkg::REG_INTR_MASK, got);
    check_value("intr_mask", {12'h000, v_imask[3:0]}, got);
    // back to a quiet state
    bus_write_word(vdp_pkg::REG_INTR_MASK, 16'h0000);
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h000f);
    bus_write_word(vdp_pkg::REG_WR_MASK, 16'h000f);
    finish_test();
endtask

task automatic test_palette_scan();
    vdp_pkg::word_t     w;
    vdp_pkg::color_idx_t idx;
    logic               prev_vs;
    int                 k;
    int                 x;
    int                 line;
    int                 h;
    start_test("palette_scan");
    bus_write_word(vdp_pkg::REG_PAL_ADDR, 16'h0000);
    for (int i = 0; i < vdp_pkg::PAL_ENTRIES; i++) begin
        pal_model[i] = vdp_pkg::word_t'(rand_bits(16));
        bus_write_word(vdp_pkg::REG_PAL_DATA, pal_model[i], LOAD_GAP);
    end
    bus_write_word(vdp_pkg::REG_VRAM_ADDR, 16'h0000);
    for (int i = 0; i < FRAME_WORDS; i++) begin
        frame_model[i] = vdp_pkg::word_t'(rand_bits(16));
        bus_write_word(vdp_pkg::REG_VRAM_DATA, frame_model[i], LOAD_GAP);
    end
    prev_vs = 1'b0;
    while (!(prev_vs && !vsync)) begin      // end of vsync, full frame follows
        prev_vs = vsync;
        @(negedge clk);
    end
    k = 0;
    h = -1;                                 // output column, unknown until first de
    while (k < FRAME_PIXELS) begin
        if (dv_de && h < 0) begin
            h = 0;
        end
        if (h >= 0) begin
            check_value("hsync", vdp_pkg::word_t'(h >= vdp_pkg::H_SYNC_START &&
                                                  h < vdp_pkg::H_SYNC_END),
                        vdp_pkg::word_t'(hsync));
        end
        check_value("vsync", 16'h0000, vdp_pkg::word_t'(vsync));  // visible lines only
        if (dv_de) begin
            line = k / vdp_pkg::H_VISIBLE;
            x    = k % vdp_pkg::H_VISIBLE;
            w    = frame_model[line * vdp_pkg::WORDS_PER_LINE + x / 2];
            idx  = (x % 2 == 0) ? w[15:8] : w[7:0];     // even pixel in high byte
            check_value($sformatf("pixel %0d,%0d", x, line),
                        {4'h0, pal_model[idx][11:0]}, {4'h0, red, green, blue});
            k++;
        end else begin
            check_value("blank rgb", 16'h0000, {4'h0, red, green, blue});
        end
        if (h >= 0) begin
            h = (h + 1) % vdp_pkg::H_TOTAL;
        end
        @(negedge clk);
    end
    finish_test();
endtask

task automatic test_interrupts();
    vdp_pkg::word_t got;
    int             n0;
    int             n1;
    start_test("interrupts");
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h000f);
    bus_write_word(vdp_pkg::REG_INTR_MASK, 16'h0002);
    intr_count_at_edge(n0);
    bus_write_word(vdp_pkg::REG_INTR_SIGNAL, 16'h0002);
    intr_count_at_edge(n1);
    check_value("first pulse count", 16'd1, vdp_pkg::word_t'(n1 - n0));
    bus_read_word(vdp_pkg::REG_INTR_CLEAR, got);                // status view
    check_value("status bit 1 set", 16'h0002, got & 16'h0002);
    intr_count_at_edge(n0);
    bus_write_word(vdp_pkg::REG_INTR_SIGNAL, 16'h0002);         // already pending
    intr_count_at_edge(n1);
    check_value("repeat pulse count", 16'd0, vdp_pkg::word_t'(n1 - n0));
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h0002);
    bus_read_word(vdp_pkg::REG_INTR_CLEAR, got);
    check_value("status bit 1 clear", 16'h0000, got & 16'h0002);
    bus_write_word(vdp_pkg::REG_INTR_MASK, 16'h0000);
    intr_count_at_edge(n0);
    bus_write_word(vdp_pkg::REG_INTR_SIGNAL, 16'h0002);         // masked off
    intr_count_at_edge(n1);
    check_value("masked pulse count", 16'd0, vdp_pkg::word_t'(n1 - n0));
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h000f);
    finish_test();
endtask

task automatic test_vblank_irq();
    vdp_pkg::word_t got;
    int             n0;
    int             n;
    int             waited;
    start_test("vblank_irq");
    bus_write_word(vdp_pkg::REG_INTR_MASK, 16'h0001);
    while (!vsync) begin
        @(negedge clk);
    end
    while (vsync) begin
        @(negedge clk);                 // just past vblank, next one a frame away
    end
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h000f);         // drop any old vblank
    intr_count_at_edge(n0);
    n      = n0;
    waited = 0;
    while (n == n0 && waited < FRAME_CYCLES + 16) begin
        intr_count_at_edge(n);
        waited++;
    end
    assert (n != n0) else begin
        $display("%s: no interrupt pulse within one frame", test_name);
        test_errors++;
    end
    bus_read_word(vdp_pkg::REG_INTR_CLEAR, got);
    check_value("status bit 0", 16'h0001, got & 16'h0001);
    bus_write_word(vdp_pkg::REG_INTR_MASK, 16'h0000);
    bus_write_word(vdp_pkg::REG_INTR_CLEAR, 16'h000f);
    finish_test();
endtask

always @(negedge clk) begin
    if (bus_intr) begin
        intr_high_cycles <= intr_high_cycles + 1;
    end
end

initial begin : watchdog
    while (cycles_in_test <= TEST_LIMIT) begin
        @(posedge clk);
        cycles_in_test++;
    end
    $display("timeout: %s ran past %0d cycles", test_name, TEST_LIMIT);
    $display("tests failed");
    $finish;
end

initial begin
    reset       = 1'b1;
    bus_cs_n    = 1'b1;
    bus_rd_nwr  = 1'b0;
    bus_reg_num = '0;
    bus_bytesel = 1'b0;
    bus_wdata   = '0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    test_vram_rw();
    test_nibble_mask();
    test_reg_readback();
    test_palette_scan();
    test_interrupts();
    test_vblank_irq();
    $display("summary: %0d of %0d tests ok, %0d errors", tests_ok, tests_run, total_errors);
    if (total_errors == 0) begin
        $display("all tests passed");
    end else begin
        $display("tests failed");
    end
    $finish;
end

endmodule

// ==== files.f ====
hdl/vdp_pkg.sv
hdl/vram_port_if.sv
hdl/vdp_regs.sv
hdl/vram_arbiter.sv
hdl/video_scan.sv
hdl/palette_out.sv
hdl/intr_ctrl.sv
hdl/vdp_top.sv
testbench/tb_clock.sv
testbench/vdp_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module vdp_tb -f files.f -o vdp_sim \
    || exit 1
./obj_dir/vdp_sim > sim.log 2>&1
cat sim.log
grep -q "tests failed" sim.log && exit 1 || grep -q "all tests passed" sim.log || exit 1
